//--- build.f
source/tpu_data_pkg.sv
source/tpu_host_pkg.sv
source/memory_bank.sv
source/weight_loader.sv
source/weight_fifo.sv
source/systolic_array.sv
source/matmul_sequencer.sv
source/tpu_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Bender.yml
package:
  name: tpu_matrix_unit

sources:
  - files:
      - source/tpu_data_pkg.sv
      - source/tpu_host_pkg.sv
      - source/memory_bank.sv
      - source/weight_loader.sv
      - source/weight_fifo.sv
      - source/systolic_array.sv
      - source/matmul_sequencer.sv
      - source/tpu_top.sv
  - target: test
    files:
      - dv/tb_checker.sv
      - dv/tb_top.sv

//--- dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import tpu_data_pkg::*;
    import tpu_host_pkg::*;
();

    localparam int WH       = 4;
    localparam int N_CASES  = 4;
    localparam int MAX_ROWS = 16;
    localparam int SEED     = 36170;
    // per case: fill + drain + rows + 2N + readback + margin for host writes
    localparam int CASE_CYCLES    = (WH + 2) + (WH + 1) + MAX_ROWS + 2 * WH
                                    + (MAX_ROWS + 2) + 322;
    localparam int TIMEOUT_CYCLES = N_CASES * CASE_CYCLES;     // 1500

    typedef elem_t     [WH-1:0] elem_row_t;
    typedef acc_t      [WH-1:0] acc_row_t;
    typedef elem_row_t [WH-1:0] tile_t;

    typedef struct packed {
        addr_t      weight_base;
        addr_t      input_base;
        addr_t      output_base;
        logic [7:0] num_rows;
        logic       all_max;        // all-255 weights and inputs
    } case_t;

    logic        clk;
    logic        rst_n;
    tpu_cmd_t    cmd;
    host_wr_t    weight_wr, input_wr;
    elem_row_t   weight_wr_data, input_wr_data;
    host_rd_t    out_rd;
    acc_row_t    out_rd_data, exp_rd_data;
    tpu_status_t status;
    int          value_errs, pulse_errs;
    int          cycles;
    int          seed, rnd;

    // ========================================
    // test table
    // ========================================
    case_t     cases   [N_CASES];
    tile_t     tbl_w   [N_CASES];
    elem_row_t tbl_in  [N_CASES][MAX_ROWS];
    acc_row_t  tbl_exp [N_CASES][MAX_ROWS];
    acc_row_t  shadow    [MEM_DEPTH];               // expected output memory
    logic      shadow_ok [MEM_DEPTH];

    tpu_top #(.WIDTH_HEIGHT(WH)) uut (
        .clk(clk), .rst_n(rst_n), .cmd(cmd),
        .weight_wr(weight_wr), .weight_wr_data(weight_wr_data),
        .input_wr(input_wr), .input_wr_data(input_wr_data),
        .out_rd(out_rd), .out_rd_data(out_rd_data), .status(status)
    );

    tb_checker #(.WIDTH_HEIGHT(WH)) chk (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .status(status), .out_rd(out_rd),
        .out_rd_data(out_rd_data), .exp_rd_data(exp_rd_data),
        .value_errs(value_errs), .pulse_errs(pulse_errs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random data, then expected rows from the model
    task automatic fill_table();
        for (int c = 0; c < N_CASES; c++) begin
            for (int i = 0; i < WH; i++) begin
                for (int j = 0; j < WH; j++) begin
                    tbl_w[c][i][j] = cases[c].all_max ? 8'hFF : elem_t'($urandom);
                end
            end
            for (int r = 0; r < MAX_ROWS; r++) begin
                for (int j = 0; j < WH; j++) begin
                    tbl_in[c][r][j] = cases[c].all_max ? 8'hFF : elem_t'($urandom);
                end
                tbl_exp[c][r] = chk.model_row(tbl_in[c][r], tbl_w[c]);
            end
        end
    endtask

    task automatic write_banks(input int c);
        for (int i = 0; i < WH; i++) begin
            @(negedge clk);
            weight_wr.en   = 1'b1;
            weight_wr.addr = addr_t'(cases[c].weight_base + i);
            weight_wr_data = tbl_w[c][i];
        end
        @(negedge clk);
        weight_wr.en = 1'b0;
        for (int r = 0; r < int'(cases[c].num_rows); r++) begin
            input_wr.en   = 1'b1;
            input_wr.addr = addr_t'(cases[c].input_base + r);
            input_wr_data = tbl_in[c][r];
            @(negedge clk);
        end
        input_wr.en = 1'b0;
    endtask

    // one-cycle strobe, 0 fill, 1 drain, 2 active
    task automatic issue(input int which, input case_t tc);
        @(negedge clk);
        cmd.weight_base = tc.weight_base;
        cmd.input_base  = tc.input_base;
        cmd.output_base = tc.output_base;
        cmd.num_rows    = tc.num_rows;
        cmd.fill_fifo   = (which == 0);
        cmd.drain_fifo  = (which == 1);
        cmd.active      = (which == 2);
        @(negedge clk);
        cmd.fill_fifo  = 1'b0;
        cmd.drain_fifo = 1'b0;
        cmd.active     = 1'b0;
    endtask

    task automatic wait_done(input int which);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            case (which)
                0:       seen = status.mem_to_fifo_done;
                1:       seen = status.fifo_to_arr_done;
                default: seen = status.output_done;
            endcase
        end
    endtask

    // result range plus one known row on each side
    task automatic read_back(input case_t tc);
        addr_t a;
        int    n;
        n = int'(tc.num_rows);
        for (int k = -1; k <= n; k++) begin
            a = addr_t'(tc.output_base + k);
            if (shadow_ok[a]) begin
                @(negedge clk);
                out_rd.en   = 1'b1;
                out_rd.addr = a;
                exp_rd_data = shadow[a];
            end
        end
        @(negedge clk);
        out_rd.en = 1'b0;
        @(negedge clk);                         // last compare lands here
    endtask

    task automatic run_case(input int c);
        case_t tc;
        tc = cases[c];
        write_banks(c);
        for (int s = 0; s < 3; s++) begin
            issue(s, tc);
            wait_done(s);
        end
        for (int r = 0; r < int'(tc.num_rows); r++) begin
            shadow[addr_t'(tc.output_base + r)]    = tbl_exp[c][r];
            shadow_ok[addr_t'(tc.output_base + r)] = 1'b1;
        end
        read_back(tc);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        rst_n          = 1'b0;
        cmd            = '0;
        weight_wr      = '0;
        weight_wr_data = '0;
        input_wr       = '0;
        input_wr_data  = '0;
        out_rd         = '0;
        exp_rd_data    = '0;
        seed           = SEED;
        rnd            = $urandom(seed);        // seeds the generator once
        for (int k = 0; k < MEM_DEPTH; k++) begin
            shadow_ok[k] = 1'b0;
        end
        // weight base, input base, output base, rows, all-255
        cases[0] = {8'h00, 8'h00, 8'h20, 8'd4,  1'b0};
        cases[1] = {8'h10, 8'h30, 8'h21, 8'd1,  1'b0};     // inside case 0 range
        cases[2] = {8'h34, 8'h50, 8'h24, 8'd9,  1'b0};
        cases[3] = {8'h08, 8'h80, 8'h2D, 8'd16, 1'b1};     // 4 x 255 x 255
        fill_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end
        repeat (4) @(negedge clk);
        $display("error count: value %0d, pulse %0d", value_errs, pulse_errs);
        if (value_errs + pulse_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a done pulse never arrived", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import tpu_data_pkg::*;
    import tpu_host_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  tpu_cmd_t                 cmd,
    input  tpu_status_t              status,
    input  host_rd_t                 out_rd,
    input  acc_t  [WIDTH_HEIGHT-1:0] out_rd_data,
    input  acc_t  [WIDTH_HEIGHT-1:0] exp_rd_data,   // expected row, driven with out_rd
    output int                       value_errs,
    output int                       pulse_errs
);

    localparam int WH = WIDTH_HEIGHT;

    typedef elem_t     [WH-1:0] elem_row_t;
    typedef acc_t      [WH-1:0] acc_row_t;
    typedef elem_row_t [WH-1:0] tile_t;          // tile[i] is weight row i

    logic [2:0] strobe_v, pulse_v;               // index 0 fill, 1 drain, 2 active
    logic [2:0] armed_q;
    int         age_q   [3];
    int         exact_q [3];                     // 0 means latency not fixed
    int         limit_q [3];
    logic       rd_pend_q;
    acc_row_t   exp_q;
    addr_t      rd_addr_q;

    assign strobe_v = {cmd.active, cmd.drain_fifo, cmd.fill_fifo};
    assign pulse_v  = {status.output_done, status.fifo_to_arr_done, status.mem_to_fifo_done};

    // ========================================
    // reference model
    // ========================================
    // out[j] = sum over i of in[i] * W[i][j], full precision
    function automatic acc_row_t model_row(input elem_row_t in_row, input tile_t w);
        acc_row_t res;
        for (int j = 0; j < WH; j++) begin
            res[j] = '0;
            for (int i = 0; i < WH; i++) begin
                res[j] = res[j] + acc_t'(in_row[i]) * acc_t'(w[i][j]);
            end
        end
        return res;
    endfunction

    function automatic string pulse_label(input int k);
        case (k)
            0:       return "mem_to_fifo_done";
            1:       return "fifo_to_arr_done";
            default: return "output_done";
        endcase
    endfunction

    // ========================================
    // done pulse tracking
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed_q    = '0;
            pulse_errs = 0;
            for (int k = 0; k < 3; k++) begin
                age_q[k]   = 0;
                exact_q[k] = 0;
                limit_q[k] = 0;
            end
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (armed_q[k]) begin
                    age_q[k]++;                             // cycles since the strobe
                    if (pulse_v[k]) begin
                        if (exact_q[k] != 0 && age_q[k] != exact_q[k]) begin
                            $display("FAIL %s latency expected 0x%h actual 0x%h",
                                     pulse_label(k), exact_q[k], age_q[k]);
                            pulse_errs++;
                        end
                        armed_q[k] = 1'b0;                  // one pulse per command
                    end else if (age_q[k] >= limit_q[k]) begin
                        $display("no %s pulse within %0d cycles of its command",
                                 pulse_label(k), limit_q[k]);
                        pulse_errs++;
                        armed_q[k] = 1'b0;
                    end
                end else if (pulse_v[k]) begin
                    $display("%s pulsed with no command pending", pulse_label(k));
                    pulse_errs++;
                end
                if (strobe_v[k]) begin
                    armed_q[k] = 1'b1;
                    age_q[k]   = 0;
                    case (k)
                        0:       exact_q[k] = WH + 2;
                        1:       exact_q[k] = WH + 1;
                        default: exact_q[k] = 0;    // varies with num_rows
                    endcase
                    limit_q[k] = (k == 2) ? int'(cmd.num_rows) + 2 * WH + 6
                                          : exact_q[k] + 4;
                end
            end
        end
    end

    // ========================================
    // readback compare
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
            exp_q     <= '0;
            rd_addr_q <= '0;
        end else begin
            rd_pend_q <= out_rd.en;
            exp_q     <= exp_rd_data;
            rd_addr_q <= out_rd.addr;
        end
    end

    initial value_errs = 0;

    // data settles one cycle after the request, compare mid-cycle
    always @(negedge clk) begin
        if (rst_n && rd_pend_q) begin
            for (int j = 0; j < WH; j++) begin
                if (out_rd_data[j] !== exp_q[j]) begin
                    $display("FAIL out_rd_data[%0d] addr 0x%h expected 0x%h actual 0x%h",
                             j, rd_addr_q, exp_q[j], out_rd_data[j]);
                    value_errs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_top
    import tpu_data_pkg::*;
    import tpu_host_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  tpu_cmd_t                 cmd,
    input  host_wr_t                 weight_wr,
    input  elem_t [WIDTH_HEIGHT-1:0] weight_wr_data,
    input  host_wr_t                 input_wr,
    input  elem_t [WIDTH_HEIGHT-1:0] input_wr_data,
    input  host_rd_t                 out_rd,
    output acc_t  [WIDTH_HEIGHT-1:0] out_rd_data,
    output tpu_status_t              status
);

    typedef elem_t [WIDTH_HEIGHT-1:0] elem_row_t;
    typedef acc_t  [WIDTH_HEIGHT-1:0] acc_row_t;

    // ========================================
    // local wires
    // ========================================
    logic      w_rd_en, w_push, fill_done;
    addr_t     w_rd_addr;
    elem_row_t w_rd_data, fifo_head;
    logic      drain_shift, drain_done;     // one level drives fifo and array
    logic      in_rd_en, in_valid;
    addr_t     in_rd_addr;
    elem_row_t in_rd_data;
    logic      res_valid, run_done;
    acc_row_t  res_row;
    host_wr_t  res_wr;

    assign status = '{mem_to_fifo_done: fill_done,
                      fifo_to_arr_done: drain_done,
                      output_done:      run_done};

    // weight side
    memory_bank #(.row_t(elem_row_t)) weight_mem (
        .clk(clk), .wr(weight_wr), .wr_data(weight_wr_data),
        .rd_en(w_rd_en), .rd_addr(w_rd_addr), .rd_data(w_rd_data)
    );

    weight_loader #(.WIDTH_HEIGHT(WIDTH_HEIGHT)) u_loader (
        .clk(clk), .rst_n(rst_n), .fill_fifo(cmd.fill_fifo), .weight_base(cmd.weight_base),
        .rd_en(w_rd_en), .rd_addr(w_rd_addr), .push(w_push), .done(fill_done)
    );

    weight_fifo #(.WIDTH_HEIGHT(WIDTH_HEIGHT)) u_fifo (
        .clk(clk), .rst_n(rst_n), .push(w_push), .push_row(w_rd_data),
        .drain_fifo(cmd.drain_fifo), .pop_row(fifo_head), .shift(drain_shift),
        .done(drain_done)
    );

    // input side and array
    memory_bank #(.row_t(elem_row_t)) input_mem (
        .clk(clk), .wr(input_wr), .wr_data(input_wr_data),
        .rd_en(in_rd_en), .rd_addr(in_rd_addr), .rd_data(in_rd_data)
    );

    systolic_array #(.WIDTH_HEIGHT(WIDTH_HEIGHT)) u_array (
        .clk(clk), .rst_n(rst_n), .w_shift(drain_shift), .w_row(fifo_head),
        .in_valid(in_valid), .in_row(in_rd_data), .out_valid(res_valid), .out_row(res_row)
    );

    matmul_sequencer #(.WIDTH_HEIGHT(WIDTH_HEIGHT)) u_seq (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .res_valid(res_valid),
        .rd_en(in_rd_en), .rd_addr(in_rd_addr), .row_valid(in_valid),
        .wr(res_wr), .done(run_done)
    );

    // output side, host reads back here
    memory_bank #(.row_t(acc_row_t)) output_mem (
        .clk(clk), .wr(res_wr), .wr_data(res_row),
        .rd_en(out_rd.en), .rd_addr(out_rd.addr), .rd_data(out_rd_data)
    );

endmodule

`default_nettype wire

//--- source/matmul_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_sequencer
    import tpu_data_pkg::*;
    import tpu_host_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire      clk,
    input  wire      rst_n,
    input  tpu_cmd_t cmd,
    input  wire      res_valid,     // out_valid from array
    output logic     rd_en,         // to input mem
    output addr_t    rd_addr,
    output logic     row_valid,     // in_valid to array
    output host_wr_t wr,            // output mem write port
    output logic     done           // output_done
);

    logic [7:0] rd_left_q;          // reads remaining after current one
    logic [7:0] wr_cnt_q;           // results written so far
    logic [7:0] num_q;
    addr_t      out_base_q;
    logic       running_q;
    logic       last_wr;

    assign last_wr = res_valid && (wr_cnt_q == num_q - 1'b1);

    // result lands at base + running count
    assign wr.en   = res_valid;
    assign wr.addr = out_base_q + wr_cnt_q;

    // ========================================
    // read side
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en     <= 1'b0;
            rd_addr   <= '0;
            rd_left_q <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= rd_en;                 // bank returns data next cycle
            if (cmd.active) begin
                rd_en     <= 1'b1;
                rd_addr   <= cmd.input_base;
                rd_left_q <= cmd.num_rows - 1'b1;
            end else if (rd_en) begin
                if (rd_left_q == '0) begin
                    rd_en <= 1'b0;
                end else begin
                    rd_left_q <= rd_left_q - 1'b1;
                    rd_addr   <= rd_addr + 1'b1;
                end
            end
        end
    end

    // ========================================
    // write side and completion
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt_q   <= '0;
            num_q      <= '0;
            out_base_q <= '0;
            running_q  <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= last_wr;
            if (cmd.active) begin
                wr_cnt_q   <= '0;
                num_q      <= cmd.num_rows;
                out_base_q <= cmd.output_base;
                running_q  <= 1'b1;
            end else if (res_valid) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
                if (last_wr) running_q <= 1'b0;
            end
        end
    end

    a_no_restart : assert property (
        @(posedge clk) disable iff (!rst_n) cmd.active |-> !running_q
    ) else $error("matmul_sequencer: active strobe during a run");

endmodule

`default_nettype wire

//--- source/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_array
    import tpu_data_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      w_shift,   // load weights top-down
    input  elem_t [WIDTH_HEIGHT-1:0] w_row,
    input  wire                      in_valid,
    input  elem_t [WIDTH_HEIGHT-1:0] in_row,
    output logic                     out_valid,
    output acc_t  [WIDTH_HEIGHT-1:0] out_row
);

    localparam int N = WIDTH_HEIGHT;

    elem_t a_edge [N];          // skewed inputs at the left edge
    elem_t a_q    [N][N-1];     // input passed right
    acc_t  ps_q   [N][N];       // partial sum passed down
    elem_t w_q    [N][N];       // stationary weights
    logic  [2*N-1:0] vld_q;     // valid ladder

    // ========================================
    // input skew with row i delayed i cycles
    // ========================================
    for (genvar gi = 0; gi < N; gi++) begin : g_skew
        if (gi == 0) begin : g_d
            assign a_edge[gi] = in_row[gi];
        end else begin : g_d
            elem_t sr_q [gi];
            always_ff @(posedge clk) begin
                sr_q[0] <= in_row[gi];
                for (int k = 1; k < gi; k++) begin
                    sr_q[k] <= sr_q[k-1];
                end
            end
            assign a_edge[gi] = sr_q[gi-1];
        end
    end

    // ========================================
    // PE grid
    // ========================================
    for (genvar gi = 0; gi < N; gi++) begin : g_row
        for (genvar gj = 0; gj < N; gj++) begin : g_pe
            elem_t a_in;
            acc_t  ps_in;
            elem_t w_in;

            if (gj == 0) begin : g_a
                assign a_in = a_edge[gi];
            end else begin : g_a
                assign a_in = a_q[gi][gj-1];
            end

            if (gi == 0) begin : g_top
                assign ps_in = '0;              // no bias
                assign w_in  = w_row[gj];       // from fifo head
            end else begin : g_top
                assign ps_in = ps_q[gi-1][gj];
                assign w_in  = w_q[gi-1][gj];
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)       w_q[gi][gj] <= '0;
                else if (w_shift) w_q[gi][gj] <= w_in;
            end

            always_ff @(posedge clk) begin
                ps_q[gi][gj] <= ps_in + a_in * w_q[gi][gj];    // full 20-bit sum
            end

            // last column has no right neighbour
            if (gj < N - 1) begin : g_pass
                always_ff @(posedge clk) begin
                    a_q[gi][gj] <= a_in;
                end
            end
        end
    end

    // deskew delays column j by N-j so every column lands at 2N
    for (genvar gj = 0; gj < N; gj++) begin : g_deskew
        acc_t dq [N-gj];
        always_ff @(posedge clk) begin
            dq[0] <= ps_q[N-1][gj];
            for (int k = 1; k < N - gj; k++) begin
                dq[k] <= dq[k-1];
            end
        end
        assign out_row[gj] = dq[N-gj-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) vld_q <= '0;
        else        vld_q <= {vld_q[2*N-2:0], in_valid};
    end

    assign out_valid = vld_q[2*N-1];

endmodule

`default_nettype wire

//--- source/weight_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module weight_fifo
    import tpu_data_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      push,
    input  elem_t [WIDTH_HEIGHT-1:0] push_row,
    input  wire                      drain_fifo,  // strobe
    output elem_t [WIDTH_HEIGHT-1:0] pop_row,     // head, oldest row
    output logic                     shift,       // drain active, also to array
    output logic                     done         // fifo_to_arr_done
);

    localparam int CNT_W = $clog2(WIDTH_HEIGHT + 1);

    elem_t [WIDTH_HEIGHT-1:0] chain_q [WIDTH_HEIGHT];  // [0] tail ... [WH-1] head
    logic  [CNT_W-1:0]        left_q;

    assign pop_row = chain_q[WIDTH_HEIGHT-1];

    // ========================================
    // shift chain
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < WIDTH_HEIGHT; k++) begin
                chain_q[k] <= '0;
            end
        end else if (push || shift) begin
            chain_q[0] <= push ? push_row : '0;     // drain back-fills zeros
            for (int k = 1; k < WIDTH_HEIGHT; k++) begin
                chain_q[k] <= chain_q[k-1];
            end
        end
    end

    // drain counter, WIDTH_HEIGHT shift cycles then done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift  <= 1'b0;
            left_q <= '0;
            done   <= 1'b0;
        end else begin
            done <= shift && (left_q == '0);
            if (drain_fifo) begin
                shift  <= 1'b1;
                left_q <= CNT_W'(WIDTH_HEIGHT - 1);
            end else if (shift) begin
                if (left_q == '0) shift <= 1'b0;
                else              left_q <= left_q - 1'b1;
            end
        end
    end

    a_push_vs_shift : assert property (
        @(posedge clk) disable iff (!rst_n) !(push && shift)
    ) else $error("weight_fifo: fill and drain overlap");

endmodule

`default_nettype wire

//--- source/weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader
    import tpu_data_pkg::*;
#(
    parameter int WIDTH_HEIGHT = 4
) (
    input  wire   clk,
    input  wire   rst_n,
    input  wire   fill_fifo,    // strobe
    input  addr_t weight_base,
    output logic  rd_en,        // to weight mem
    output addr_t rd_addr,
    output logic  push,         // to fifo, data is rd_data of weight mem
    output logic  done          // mem_to_fifo_done
);

    localparam int CNT_W = $clog2(WIDTH_HEIGHT + 1);

    logic [CNT_W-1:0] left_q;   // reads remaining after current one
    logic             busy;

    assign busy = rd_en | push;

    // ========================================
    // descending read walk
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
            left_q  <= '0;
        end else if (fill_fifo) begin
            rd_en   <= 1'b1;
            rd_addr <= weight_base + addr_t'(WIDTH_HEIGHT - 1);   // top row first
            left_q  <= CNT_W'(WIDTH_HEIGHT - 1);
        end else if (rd_en) begin
            if (left_q == '0) begin
                rd_en <= 1'b0;                  // base row was the last read
            end else begin
                left_q  <= left_q - 1'b1;
                rd_addr <= rd_addr - 1'b1;
            end
        end
    end

    // push trails the read by the bank latency, done follows last push
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
            done <= 1'b0;
        end else begin
            push <= rd_en;
            done <= push & ~rd_en;
        end
    end

    a_no_refill : assert property (
        @(posedge clk) disable iff (!rst_n) fill_fifo |-> !busy
    ) else $error("weight_loader: fill_fifo while a fill is running");

endmodule

`default_nettype wire

//--- source/memory_bank.sv
`timescale 1ns/1ps
`default_nettype none

module memory_bank
    import tpu_host_pkg::*;
#(
    parameter type row_t = logic [7:0]  // one full row per address
) (
    input  wire      clk,
    input  host_wr_t wr,
    input  row_t     wr_data,
    input  wire      rd_en,
    input  addr_t    rd_addr,
    output row_t     rd_data
);

    row_t mem [MEM_DEPTH];      // storage, no reset

    // ========================================
    // write port
    // ========================================
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr_data;
        end
    end

    // registered read, holds last value when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // read-during-write on one address has no defined order here
    a_no_rw_collide : assert property (
        @(posedge clk) !(wr.en && rd_en && (wr.addr == rd_addr))
    ) else $error("memory_bank: write and read hit address %0h together", rd_addr);

endmodule

`default_nettype wire

//--- source/tpu_host_pkg.sv
`default_nettype none

package tpu_host_pkg;

    import tpu_data_pkg::*;

    // banks see their addressing through this package
    export tpu_data_pkg::addr_t;
    export tpu_data_pkg::MEM_DEPTH;

    // bank write port, row data travels beside it
    typedef struct packed {
        logic  en;
        addr_t addr;
    } host_wr_t;

    // registered read request
    typedef struct packed {
        logic  en;
        addr_t addr;
    } host_rd_t;

    // ========================================
    // command strobes and run setup
    // ========================================
    typedef struct packed {
        logic       fill_fifo;      // weight mem -> fifo
        logic       drain_fifo;     // fifo -> array
        logic       active;         // start a compute run
        logic [7:0] num_rows;       // 1..255
        addr_t      weight_base;
        addr_t      input_base;
        addr_t      output_base;
    } tpu_cmd_t;

    // one-cycle completion pulses
    typedef struct packed {
        logic mem_to_fifo_done;
        logic fifo_to_arr_done;
        logic output_done;
    } tpu_status_t;

endpackage

`default_nettype wire

//--- source/tpu_data_pkg.sv
`default_nettype none

package tpu_data_pkg;

    // ========================================
    // element and accumulator types
    // ========================================
    typedef logic [7:0] elem_t;     // unsigned weight / input element

    // 20 bits holds 4 products of 255 x 255 without overflow
    // a grid wider than 4 needs a wider accumulator here
    typedef logic [19:0] acc_t;

    // ========================================
    // addressing
    // ========================================
    typedef logic [7:0] addr_t;     // row address, all three banks

    localparam int MEM_DEPTH = 256; // rows per bank

endpackage

`default_nettype wire
